// File: axis_index_pipeline.f
+incdir+include
source/axis_beat_pkg.sv
source/frame_pkg.sv
source/axi_stream.sv
source/axis_skid_buffer.sv
source/axis_beat_indexer.sv
source/axis_index_pipeline.sv
sim/tb_clock_gen.sv
sim/tb_axis_index_pipeline.sv

// File: include/axis_consts.svh
// ~~~~~~~~~~~~~~~~~~~~
// Field widths for the stream beats and the frame counter
// Include wherever a width is needed
// ~~~~~~~~~~~~~~~~~~~~

`ifndef AXIS_CONSTS_SVH
`define AXIS_CONSTS_SVH

// Payload fields of one stream beat
`define AXIS_DATA_WIDTH 32
`define AXIS_DEST_WIDTH 8

// The user field carries the beat index, so it also limits frame length
`define AXIS_USER_WIDTH 16

// Frames completed since reset, wraps at the top
`define FRAME_COUNT_WIDTH 16

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and passes only on the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_axis_index_pipeline \
    -f axis_index_pipeline.f \
    -Mdir obj_dir -o sim_axis_index_pipeline \
    || { echo "Verilator build failed"; exit 1; }

sim_output="$(./obj_dir/sim_axis_index_pipeline)"
echo "$sim_output"

echo "$sim_output" | grep -q "^TEST OK$" && exit 0 || exit 1

// File: sim/tb_axis_index_pipeline.sv
// ~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the stream slice, runs five tests and reports the result
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "axis_consts.svh"

module tb_axis_index_pipeline;

    // Longest wait in clock cycles for any single event
    localparam int wait_limit = 400;

    logic                        clock;
    logic                        reset;
    logic                        in_valid;
    logic                        in_ready;
    logic [`AXIS_DATA_WIDTH-1:0] in_data;
    logic [`AXIS_DEST_WIDTH-1:0] in_dest;
    logic [`AXIS_USER_WIDTH-1:0] in_user;
    logic                        in_tlast;
    logic                        out_valid;
    logic                        out_ready;
    logic [`AXIS_DATA_WIDTH-1:0] out_data;
    logic [`AXIS_DEST_WIDTH-1:0] out_dest;
    logic [`AXIS_USER_WIDTH-1:0] out_user;
    logic                        out_tlast;
    frame_pkg::frame_count_t     frame_count;

    integer seed;
    int     cycle_count;
    int     error_count;
    int     test_count;
    int     failed_tests;
    bit     aborted;

    // Frames sent since reset, counted from the tlast beats of the stimulus
    frame_pkg::frame_count_t frames_expected;

    axis_beat_pkg::beat_t tx_beats[$];
    axis_beat_pkg::beat_t exp_beats[$];
    axis_beat_pkg::beat_t rx_beats[$];
    int                   rx_cycles[$];
    axis_beat_pkg::beat_t observed;

    tb_clock_gen u_clock_gen (
        .clock(clock),
        .reset(reset)
    );

    axis_index_pipeline u_axis_index_pipeline (
        .clock(clock),
        .reset(reset),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .in_data(in_data),
        .in_dest(in_dest),
        .in_user(in_user),
        .in_tlast(in_tlast),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_data(out_data),
        .out_dest(out_dest),
        .out_user(out_user),
        .out_tlast(out_tlast),
        .frame_count(frame_count)
    );

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    // Handshakes are sampled at the falling edge, where all inputs and outputs have settled
    always @(negedge clock) begin
        if (reset === 1'b1 && out_valid === 1'b1 && out_ready === 1'b1) begin
            observed.data  = out_data;
            observed.dest  = out_dest;
            observed.user  = out_user;
            observed.tlast = out_tlast;
            rx_beats.push_back(observed);
            rx_cycles.push_back(cycle_count);
        end
    end

    // Fields are printed as data/dest/user/tlast
    task automatic compare_beat(input string test, input int position,
                                input axis_beat_pkg::beat_t expected,
                                input axis_beat_pkg::beat_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch %s beat %0d: expected %h/%h/%h/%b actual %h/%h/%h/%b",
                     test, position, expected.data, expected.dest, expected.user,
                     expected.tlast, actual.data, actual.dest, actual.user, actual.tlast);
        end
    endtask

    task automatic compare_count(input string test, input frame_pkg::frame_count_t expected,
                                 input frame_pkg::frame_count_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch %s frame_count: expected %0d actual %0d",
                     test, expected, actual);
        end
    endtask

    task automatic compare_flag(input string test, input string what,
                                input logic expected, input logic actual);
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch %s %s: expected %b actual %b", test, what, expected, actual);
        end
    endtask

    task automatic compare_number(input string test, input string what,
                                  input int expected, input int actual);
        if (actual != expected) begin
            error_count++;
            $display("Mismatch %s %s: expected %0d actual %0d", test, what, expected, actual);
        end
    endtask

    task automatic report_timeout(input string test, input string what);
        error_count++;
        aborted = 1'b1;
        $display("Timeout in %s: %s", test, what);
    endtask

    task automatic finish_test(input string test, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("%s: passed", test);
        end else begin
            failed_tests++;
            $display("%s: failed with %0d errors", test, error_count - errors_before);
        end
    endtask

    function automatic axis_beat_pkg::beat_t random_beat(input logic tlast);
        axis_beat_pkg::beat_t beat;
        logic [31:0]          word;
        word = $random(seed);
        beat.data = word[`AXIS_DATA_WIDTH-1:0];
        word = $random(seed);
        beat.dest = word[`AXIS_DEST_WIDTH-1:0];
        beat.user = word[`AXIS_DEST_WIDTH +: `AXIS_USER_WIDTH];
        beat.tlast = tlast;
        return beat;
    endfunction

    task automatic append_frame(input int length);
        int i;
        for (i = 0; i < length; i++) begin
            tx_beats.push_back(random_beat(i == length - 1));
        end
    endtask

    // User becomes the position in the frame, the rest of the beat is unchanged
    task automatic build_expected(output int tlast_total);
        frame_pkg::beat_index_t index;
        axis_beat_pkg::beat_t   beat;
        int                     i;
        exp_beats.delete();
        index = '0;
        tlast_total = 0;
        for (i = 0; i < tx_beats.size(); i++) begin
            beat = tx_beats[i];
            beat.user = index;
            exp_beats.push_back(beat);
            if (beat.tlast) begin
                index = '0;
                tlast_total++;
            end else begin
                index++;
            end
        end
    endtask

    task automatic drive_payload(input axis_beat_pkg::beat_t beat);
        in_data  = beat.data;
        in_dest  = beat.dest;
        in_user  = beat.user;
        in_tlast = beat.tlast;
    endtask

    // Offers every beat of tx_beats in turn and holds it until the DUT takes it
    task automatic send_stream(input bit toggle_ready, output int accept_cycle,
                               output int stall_cycles, output bit timed_out);
        int          sent;
        int          cycles;
        int          limit;
        logic [31:0] word;
        sent = 0;
        cycles = 0;
        stall_cycles = 0;
        accept_cycle = -1;
        timed_out = 1'b0;
        limit = 20 * tx_beats.size() + 100;
        while (sent < tx_beats.size() && !timed_out) begin
            in_valid = 1'b1;
            drive_payload(tx_beats[sent]);
            if (toggle_ready) begin
                word = $random(seed);
                out_ready = word[0];
            end
            @(negedge clock);
            if (in_ready === 1'b1) begin
                if (sent == 0) begin
                    accept_cycle = cycle_count;
                end
                sent++;
            end else begin
                stall_cycles++;
            end
            cycles++;
            if (sent < tx_beats.size() && cycles >= limit) begin
                timed_out = 1'b1;
            end
            @(posedge clock);
            #2;
        end
        in_valid = 1'b0;
        drive_payload('0);
    endtask

    task automatic wait_for_beats(input int total, output bit timed_out);
        int waited;
        waited = 0;
        timed_out = 1'b0;
        while (rx_beats.size() < total && !timed_out) begin
            @(posedge clock);
            #2;
            waited++;
            if (rx_beats.size() < total && waited >= wait_limit) begin
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic idle_cycles(input int cycles);
        int i;
        for (i = 0; i < cycles; i++) begin
            @(posedge clock);
        end
        #2;
    endtask

    task automatic send_and_check(input string test, input bit toggle_ready, output int base,
                                  output int accept_cycle, output int stall_cycles);
        int tlast_total;
        int i;
        bit timed_out;
        base = rx_beats.size();
        build_expected(tlast_total);
        frames_expected = frames_expected + frame_pkg::frame_count_t'(tlast_total);
        send_stream(toggle_ready, accept_cycle, stall_cycles, timed_out);
        out_ready = 1'b1;
        if (timed_out) begin
            report_timeout(test, "the DUT stopped accepting input beats");
            return;
        end
        wait_for_beats(base + exp_beats.size(), timed_out);
        if (timed_out) begin
            report_timeout(test, "not all beats came out of the DUT");
            return;
        end
        // A few quiet cycles expose any duplicated beat
        idle_cycles(4);
        compare_number(test, "output beat count", exp_beats.size(), rx_beats.size() - base);
        for (i = 0; i < exp_beats.size(); i++) begin
            compare_beat(test, i, exp_beats[i], rx_beats[base + i]);
        end
        compare_count(test, frames_expected, frame_count);
    endtask

    task automatic test_reset_state;
        int errors_before;
        int waited;
        bit released;
        errors_before = error_count;
        waited = 0;
        released = 1'b0;
        while (!released && waited < wait_limit) begin
            @(negedge clock);
            waited++;
            if (reset === 1'b1) begin
                released = 1'b1;
            end else if (cycle_count > 0) begin
                compare_flag("reset_state", "out_valid in reset", 1'b0, out_valid);
                compare_flag("reset_state", "in_ready in reset", 1'b0, in_ready);
                compare_count("reset_state", '0, frame_count);
            end
        end
        if (!released) begin
            report_timeout("reset_state", "reset was never released");
        end else begin
            // Ready is registered from reset, so it is still low here
            compare_flag("reset_state", "out_valid after release", 1'b0, out_valid);
            compare_flag("reset_state", "in_ready after release", 1'b0, in_ready);
            compare_count("reset_state", '0, frame_count);
            @(negedge clock);
            compare_flag("reset_state", "in_ready one cycle later", 1'b1, in_ready);
        end
        @(posedge clock);
        #2;
        finish_test("reset_state", errors_before);
    endtask

    task automatic test_single_frame;
        int errors_before;
        int base;
        int accept_cycle;
        int stall_cycles;
        errors_before = error_count;
        tx_beats.delete();
        append_frame(5);
        send_and_check("single_frame", 1'b0, base, accept_cycle, stall_cycles);
        finish_test("single_frame", errors_before);
    endtask

    task automatic test_back_to_back;
        int errors_before;
        int base;
        int accept_cycle;
        int stall_cycles;
        errors_before = error_count;
        tx_beats.delete();
        append_frame(1);
        append_frame(3);
        append_frame(2);
        send_and_check("back_to_back", 1'b0, base, accept_cycle, stall_cycles);
        finish_test("back_to_back", errors_before);
    endtask

    task automatic test_back_pressure;
        int errors_before;
        int base;
        int accept_cycle;
        int stall_cycles;
        errors_before = error_count;
        tx_beats.delete();
        append_frame(4);
        append_frame(7);
        append_frame(1);
        append_frame(5);
        append_frame(3);
        send_and_check("back_pressure", 1'b1, base, accept_cycle, stall_cycles);
        finish_test("back_pressure", errors_before);
    endtask

    task automatic test_full_throughput;
        int errors_before;
        int base;
        int accept_cycle;
        int stall_cycles;
        int latency;
        int i;
        errors_before = error_count;
        tx_beats.delete();
        for (i = 0; i < 16; i++) begin
            tx_beats.push_back(random_beat(i % 4 == 3));
        end
        out_ready = 1'b1;
        send_and_check("full_throughput", 1'b0, base, accept_cycle, stall_cycles);
        if (!aborted && rx_cycles.size() > base) begin
            latency = rx_cycles[base] - accept_cycle;
            compare_number("full_throughput", "input stall cycles", 0, stall_cycles);
            compare_number("full_throughput", "first beat latency", 1, latency);
        end
        finish_test("full_throughput", errors_before);
    endtask

    initial begin
        seed = 32'h49ad;
        error_count = 0;
        test_count = 0;
        failed_tests = 0;
        aborted = 1'b0;
        frames_expected = '0;
        in_valid = 1'b0;
        in_data = '0;
        in_dest = '0;
        in_user = '0;
        in_tlast = 1'b0;
        out_ready = 1'b1;

        test_reset_state();
        if (!aborted) begin
            test_single_frame();
        end
        if (!aborted) begin
            test_back_to_back();
        end
        if (!aborted) begin
            test_back_pressure();
        end
        if (!aborted) begin
            test_full_throughput();
        end

        $display("Tests run %0d, tests failed %0d, errors %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: sim/tb_clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~
// Clock and reset source for the testbench, 40 ns period
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module tb_clock_gen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Reset covers the first two rising edges and is released just after the second
    initial begin
        reset = 1'b0;
        repeat (2) @(posedge clock);
        #2;
        reset = 1'b1;
    end

endmodule

// File: source/axi_stream.sv
// ~~~~~~~~~~~~~~~~~~~~
// Stream bundle that joins the internal pipeline stages
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "axis_consts.svh"

interface axi_stream;

    logic                        valid;
    logic                        ready;
    logic [`AXIS_DATA_WIDTH-1:0] data;
    logic [`AXIS_DEST_WIDTH-1:0] dest;
    logic [`AXIS_USER_WIDTH-1:0] user;
    logic                        tlast;

    // The sender owns valid and the payload, the receiver owns ready
    modport master (output valid, output data, output dest, output user, output tlast,
                    input ready);

    modport slave (input valid, input data, input dest, input user, input tlast,
                   output ready);

endinterface

// File: source/axis_beat_indexer.sv
// ~~~~~~~~~~~~~~~~~~~~
// Stamps each beat's user field with its position in the frame
// and counts completed frames
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module axis_beat_indexer (
    input  logic                    clock,
    input  logic                    reset,
    axi_stream.slave                axis_in,
    axi_stream.master               axis_out,
    output frame_pkg::frame_count_t frame_count
);

    frame_pkg::beat_index_t  beat_index;
    frame_pkg::frame_count_t frame_count_q;
    logic                    out_handshake;

    // Handshake and payload pass straight through this stage
    assign axis_out.valid = axis_in.valid;
    assign axis_in.ready  = axis_out.ready;
    assign axis_out.data  = axis_in.data;
    assign axis_out.dest  = axis_in.dest;
    assign axis_out.tlast = axis_in.tlast;

    // Only the user field is replaced
    assign axis_out.user = beat_index;

    assign out_handshake = axis_out.valid && axis_out.ready;

    // Beat index restarts after the last beat of each frame
    always_ff @(posedge clock) begin
        if (!reset) begin
            beat_index <= '0;
        end else if (out_handshake) begin
            if (axis_in.tlast) begin
                beat_index <= '0;
            end else begin
                beat_index <= beat_index + 1'b1;
            end
        end
    end

    // Frame counter wraps at the top
    always_ff @(posedge clock) begin
        if (!reset) begin
            frame_count_q <= '0;
        end else if (out_handshake && axis_in.tlast) begin
            frame_count_q <= frame_count_q + 1'b1;
        end
    end

    assign frame_count = frame_count_q;

    // Whenever a frame has just completed, the next one starts at index 0
    assert property (@(posedge clock) disable iff (!reset)
        (frame_count_q != $past(frame_count_q)) |-> (beat_index == '0));

endmodule

// File: source/axis_beat_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Packed beat type shared by the stream stages and the testbench
// ~~~~~~~~~~~~~~~~~~~~

`include "axis_consts.svh"

package axis_beat_pkg;

    // One stream beat, 57 bits with data in the top bits
    typedef struct packed {
        logic [`AXIS_DATA_WIDTH-1:0] data;
        logic [`AXIS_DEST_WIDTH-1:0] dest;
        logic [`AXIS_USER_WIDTH-1:0] user;
        logic                        tlast;
    } beat_t;

endpackage

// File: source/axis_index_pipeline.sv
// ~~~~~~~~~~~~~~~~~~~~
// Top level of the stream slice: input skid buffer, beat indexer,
// output skid buffer, all behind plain stream ports
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "axis_consts.svh"

module axis_index_pipeline (
    input  logic                        clock,
    input  logic                        reset,

    input  logic                        in_valid,
    output logic                        in_ready,
    input  logic [`AXIS_DATA_WIDTH-1:0] in_data,
    input  logic [`AXIS_DEST_WIDTH-1:0] in_dest,
    input  logic [`AXIS_USER_WIDTH-1:0] in_user,
    input  logic                        in_tlast,

    output logic                        out_valid,
    input  logic                        out_ready,
    output logic [`AXIS_DATA_WIDTH-1:0] out_data,
    output logic [`AXIS_DEST_WIDTH-1:0] out_dest,
    output logic [`AXIS_USER_WIDTH-1:0] out_user,
    output logic                        out_tlast,

    output frame_pkg::frame_count_t     frame_count
);

    axi_stream port_in ();
    axi_stream stream_a ();
    axi_stream stream_b ();
    axi_stream port_out ();

    assign port_in.valid = in_valid;
    assign port_in.data  = in_data;
    assign port_in.dest  = in_dest;
    assign port_in.user  = in_user;
    assign port_in.tlast = in_tlast;
    assign in_ready      = port_in.ready;

    assign out_valid      = port_out.valid;
    assign out_data       = port_out.data;
    assign out_dest       = port_out.dest;
    assign out_user       = port_out.user;
    assign out_tlast      = port_out.tlast;
    assign port_out.ready = out_ready;

    // Registered input stage gives the one cycle of latency
    axis_skid_buffer #(
        .register_output(1),
        .latching(0)
    ) u_skid_in (
        .clock(clock),
        .reset(reset),
        .axis_in(port_in.slave),
        .axis_out(stream_a.master)
    );

    axis_beat_indexer u_indexer (
        .clock(clock),
        .reset(reset),
        .axis_in(stream_a.slave),
        .axis_out(stream_b.master),
        .frame_count(frame_count)
    );

    // Output stage only breaks the ready path back to the indexer
    axis_skid_buffer #(
        .register_output(0),
        .latching(0)
    ) u_skid_out (
        .clock(clock),
        .reset(reset),
        .axis_in(stream_b.slave),
        .axis_out(port_out.master)
    );

endmodule

// File: source/axis_skid_buffer.sv
// ~~~~~~~~~~~~~~~~~~~~
// One-slot stream skid buffer, output either registered or passed through
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module axis_skid_buffer #(
    parameter register_output = 1,
    parameter latching = 0
) (
    input logic       clock,
    input logic       reset,
    axi_stream.slave  axis_in,
    axi_stream.master axis_out
);

    // Beats in flight once one of them has to wait in the slot
    localparam logic [1:0] slot_level = register_output ? 2'd2 : 2'd1;

    axis_beat_pkg::beat_t in_beat;
    axis_beat_pkg::beat_t slot;
    axis_beat_pkg::beat_t out_beat;
    logic                 out_valid;
    logic                 in_handshake;
    logic                 out_handshake;
    logic                 output_stalled;
    logic                 skidding;
    logic                 ready_armed;
    logic [1:0]           held_beats;

    assign in_beat.data  = axis_in.data;
    assign in_beat.dest  = axis_in.dest;
    assign in_beat.user  = axis_in.user;
    assign in_beat.tlast = axis_in.tlast;

    assign in_handshake   = axis_in.valid && axis_in.ready;
    assign out_handshake  = axis_out.valid && axis_out.ready;
    assign output_stalled = axis_out.valid && !axis_out.ready;

    // A beat accepted while the output stalls has to wait in the slot
    always_ff @(posedge clock) begin
        if (!reset) begin
            skidding <= 1'b0;
        end else if (in_handshake && output_stalled) begin
            skidding <= 1'b1;
        end else if (axis_out.ready) begin
            skidding <= 1'b0;
        end
    end

    // Ready stays low for one cycle after reset is released
    always_ff @(posedge clock) begin
        if (!reset) begin
            ready_armed <= 1'b0;
        end else begin
            ready_armed <= 1'b1;
        end
    end

    assign axis_in.ready = ready_armed && !skidding;

    // The slot always keeps the last accepted beat
    // skidding tells whether it still has to be sent
    always_ff @(posedge clock) begin
        if (in_handshake) begin
            slot <= in_beat;
        end
    end

    // Beats taken in and not yet handed on, from the handshakes on both sides
    always_ff @(posedge clock) begin
        if (!reset) begin
            held_beats <= '0;
        end else if (in_handshake && !out_handshake) begin
            held_beats <= held_beats + 2'd1;
        end else if (!in_handshake && out_handshake) begin
            held_beats <= held_beats - 2'd1;
        end
    end

    generate
        if (register_output) begin : g_registered
            logic load_output;

            // The output register only moves when it is empty or being taken
            assign load_output = !out_valid || axis_out.ready;

            always_ff @(posedge clock) begin
                if (!reset) begin
                    out_valid <= 1'b0;
                end else if (load_output) begin
                    out_valid <= skidding || in_handshake;
                end
            end

            always_ff @(posedge clock) begin
                if (load_output) begin
                    if (skidding) begin
                        out_beat <= slot;
                    end else if (in_handshake) begin
                        out_beat <= in_beat;
                    end else if (!latching) begin
                        out_beat <= '0;
                    end
                end
            end

            // A stalled beat must not change under the receiver
            assert property (@(posedge clock) disable iff (!reset)
                (out_valid && !axis_out.ready) |=> (out_valid && $stable(out_beat)));
        end else begin : g_passthrough
            // The held beat goes first, otherwise the input flows straight out
            assign out_valid = skidding || in_handshake;

            always_comb begin
                if (skidding) begin
                    out_beat = slot;
                end else if (axis_in.valid) begin
                    out_beat = in_beat;
                end else if (latching) begin
                    out_beat = slot;
                end else begin
                    out_beat = '0;
                end
            end
        end
    endgenerate

    assign axis_out.valid = out_valid;
    assign axis_out.data  = out_beat.data;
    assign axis_out.dest  = out_beat.dest;
    assign axis_out.user  = out_beat.user;
    assign axis_out.tlast = out_beat.tlast;

    // Upstream never sees ready while a beat waits in the slot
    assert property (@(posedge clock) disable iff (!reset)
        (held_beats >= slot_level) |-> !axis_in.ready);

endmodule

// File: source/frame_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Types for frame bookkeeping, beat position and frame count
// ~~~~~~~~~~~~~~~~~~~~

`include "axis_consts.svh"

package frame_pkg;

    // Position of a beat inside its frame, 0 for the first beat
    typedef logic [`AXIS_USER_WIDTH-1:0] beat_index_t;

    // Completed frames since reset
    typedef logic [`FRAME_COUNT_WIDTH-1:0] frame_count_t;

endpackage
